// File: filelist.f
src/rob_pkg.sv
src/rob_queue_ctrl.sv
src/rob_entry_array.sv
src/rob_retire.sv
src/rob_top.sv
verif/rob_clock_gen.sv
verif/rob_assertions.sv
verif/rob_tb.sv

// File: src/rob_entry_array.sv
`timescale 1ns/1ns

module rob_entry_array import rob_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n_i,

    // dispatch write at the tail
    input  logic                            wr_en_i,
    input  logic [TAG_W-1:0]                wr_tag_i,
    input  logic [CLASS_W-1:0]              wr_class_i,
    input  logic [4:0]                      wr_rd_i,

    // common data bus, one slice per lane
    input  logic [NUM_CDB-1:0]              cdb_valid_i,
    input  logic [NUM_CDB-1:0][TAG_W-1:0]   cdb_tag_i,
    input  logic [NUM_CDB-1:0][XLEN-1:0]    cdb_value_i,
    input  logic [NUM_CDB-1:0][XLEN-1:0]    cdb_target_i,

    // retire side
    input  logic [TAG_W-1:0]                head_ptr_i,
    input  logic                            retire_head_i,
    input  logic                            flush_i,

    // head entry fields for the retire logic
    output logic                            head_busy_o,
    output logic                            head_done_o,
    output logic [CLASS_W-1:0]              head_class_o,
    output logic [4:0]                      head_rd_o,
    output logic [XLEN-1:0]                 head_value_o,
    output logic [XLEN-1:0]                 head_target_o
);

    // per-entry state flags
    logic [ROB_ENTRIES-1:0] busy_q;
    logic [ROB_ENTRIES-1:0] done_q;

    // per-entry payload
    logic [CLASS_W-1:0] class_q  [ROB_ENTRIES];
    logic [4:0]         rd_q     [ROB_ENTRIES];
    logic [XLEN-1:0]    value_q  [ROB_ENTRIES];
    logic [XLEN-1:0]    target_q [ROB_ENTRIES];

    // lane carries a result this ROB still waits for
    logic [NUM_CDB-1:0] cdb_hit;

    // tag match against occupied entries that are not done
    // tag 0, free entries and finished entries fall through
    always_comb begin
        for (int l = 0; l < NUM_CDB; l++) begin
            cdb_hit[l] = cdb_valid_i[l]
                      && (cdb_tag_i[l] != '0)
                      && busy_q[cdb_tag_i[l]]
                      && !done_q[cdb_tag_i[l]];
        end
    end

    // busy and done bookkeeping
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
            done_q <= '0;
        end else if (flush_i) begin
            // every entry freed at once
            busy_q <= '0;
            done_q <= '0;
        end else begin
            // head leaves the buffer
            if (retire_head_i) begin
                busy_q[head_ptr_i] <= 1'b0;
                done_q[head_ptr_i] <= 1'b0;
            end
            // new entry starts out waiting for its result
            if (wr_en_i) begin
                busy_q[wr_tag_i] <= 1'b1;
                done_q[wr_tag_i] <= 1'b0;
            end
            // results arriving on the bus
            for (int l = 0; l < NUM_CDB; l++) begin
                if (cdb_hit[l]) begin
                    done_q[cdb_tag_i[l]] <= 1'b1;
                end
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            class_q[wr_tag_i] <= wr_class_i;
            rd_q[wr_tag_i]    <= wr_rd_i;
        end
        // value and target captured together
        for (int l = 0; l < NUM_CDB; l++) begin
            if (cdb_hit[l]) begin
                value_q[cdb_tag_i[l]]  <= cdb_value_i[l];
                target_q[cdb_tag_i[l]] <= cdb_target_i[l];
            end
        end
    end

    // head read port
    assign head_busy_o   = busy_q[head_ptr_i];
    assign head_done_o   = done_q[head_ptr_i];
    assign head_class_o  = class_q[head_ptr_i];
    assign head_rd_o     = rd_q[head_ptr_i];
    assign head_value_o  = value_q[head_ptr_i];
    assign head_target_o = target_q[head_ptr_i];

endmodule

// File: src/rob_pkg.sv
package rob_pkg;

    // entry 0 is the null tag and never holds an instruction
    localparam int ROB_ENTRIES = 8;

    // entries a program can actually occupy
    localparam int ROB_USABLE = ROB_ENTRIES - 1;

    // tag indexes the full entry space including entry 0
    localparam int TAG_W = 3;

    // occupancy count has to reach ROB_USABLE
    localparam int CNT_W = 4;

    // lanes on the common data bus
    localparam int NUM_CDB = 2;

    // data path width of the rv32i core
    localparam int XLEN = 32;

    // instruction class field width
    localparam int CLASS_W = 2;

    // instruction classes as seen by the ROB
    // alu ops and loads write rd at commit
    localparam logic [CLASS_W-1:0] CLS_ALU = 2'd0;
    localparam logic [CLASS_W-1:0] CLS_LOAD = 2'd1;

    // store waits for the lsq before leaving the head
    localparam logic [CLASS_W-1:0] CLS_STORE = 2'd2;

    // branch value bit 0 set means redirect and flush
    localparam logic [CLASS_W-1:0] CLS_BRANCH = 2'd3;

endpackage

// File: src/rob_queue_ctrl.sv
`timescale 1ns/1ns

module rob_queue_ctrl import rob_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,

    // dispatch request from decoder
    input  logic             disp_valid_i,

    // head retires this cycle
    input  logic             retire_head_i,

    // redirect branch at the head clears the queue
    input  logic             flush_i,

    output logic [TAG_W-1:0] head_ptr_o,
    output logic [TAG_W-1:0] tail_ptr_o,
    output logic             disp_accept_o,
    output logic             full_o,
    output logic             empty_o,
    output logic [TAG_W-1:0] disp_tag_o
);

    logic [TAG_W-1:0] head_ptr_q;
    logic [TAG_W-1:0] tail_ptr_q;

    // number of occupied entries, 0 to ROB_USABLE
    logic [CNT_W-1:0] occ_cnt_q;

    // circular increment that skips reserved entry 0
    function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
        logic [TAG_W-1:0] nxt;
        if (ptr == TAG_W'(ROB_ENTRIES - 1)) begin
            nxt = TAG_W'(1);
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // status straight from the count
    assign full_o  = (occ_cnt_q == CNT_W'(ROB_USABLE));
    assign empty_o = (occ_cnt_q == '0);

    // full is the only back-pressure
    // a dispatch racing a flush is dropped
    assign disp_accept_o = disp_valid_i && !full_o && !flush_i;

    assign head_ptr_o = head_ptr_q;
    assign tail_ptr_o = tail_ptr_q;

    // tag the next accepted dispatch will receive
    assign disp_tag_o = tail_ptr_q;

    // head pointer
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_ptr_q <= TAG_W'(1);
        end else if (flush_i) begin
            head_ptr_q <= TAG_W'(1);
        end else if (retire_head_i) begin
            head_ptr_q <= next_ptr(head_ptr_q);
        end
    end

    // tail pointer
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tail_ptr_q <= TAG_W'(1);
        end else if (flush_i) begin
            tail_ptr_q <= TAG_W'(1);
        end else if (disp_accept_o) begin
            tail_ptr_q <= next_ptr(tail_ptr_q);
        end
    end

    // occupancy
    // dispatch and retire together leave the count alone
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occ_cnt_q <= '0;
        end else if (flush_i) begin
            occ_cnt_q <= '0;
        end else begin
            case ({disp_accept_o, retire_head_i})
                2'b10: occ_cnt_q <= occ_cnt_q + 1'b1;
                2'b01: occ_cnt_q <= occ_cnt_q - 1'b1;
                default: occ_cnt_q <= occ_cnt_q;
            endcase
        end
    end

endmodule

// File: src/rob_retire.sv
`timescale 1ns/1ns

module rob_retire import rob_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,

    // head entry as seen in the array
    input  logic [TAG_W-1:0]   head_ptr_i,
    input  logic               head_busy_i,
    input  logic               head_done_i,
    input  logic [CLASS_W-1:0] head_class_i,
    input  logic [4:0]         head_rd_i,
    input  logic [XLEN-1:0]    head_value_i,
    input  logic [XLEN-1:0]    head_target_i,

    // pulse from the lsq once the head store is performed
    input  logic               store_done_i,

    output logic               retire_head_o,
    output logic               flush_o,
    output logic               head_is_store_o,

    // commit to regfile and reservation stations
    output logic               commit_valid_o,
    output logic [TAG_W-1:0]   commit_tag_o,
    output logic [4:0]         commit_rd_o,
    output logic [XLEN-1:0]    commit_value_o,

    // redirect to fetch
    output logic               redirect_o,
    output logic [XLEN-1:0]    redirect_pc_o
);

    // decode of the head entry
    logic head_writes_rd;
    logic head_is_branch;
    logic do_commit;
    logic do_store;
    logic do_branch;
    logic do_redirect;

    assign head_writes_rd = (head_class_i == CLS_ALU) || (head_class_i == CLS_LOAD);
    assign head_is_branch = (head_class_i == CLS_BRANCH);

    // lsq may only perform the store sitting at the head
    assign head_is_store_o = head_busy_i && (head_class_i == CLS_STORE);

    // alu op or load with its result back
    assign do_commit = head_busy_i && head_done_i && head_writes_rd;

    // store leaves on the lsq pulse, no commit
    assign do_store = head_is_store_o && store_done_i;

    // any resolved branch leaves the head
    assign do_branch = head_busy_i && head_done_i && head_is_branch;

    // bit 0 of a branch result asks for a redirect
    assign do_redirect = do_branch && head_value_i[0];

    assign retire_head_o = do_commit || do_store || do_branch;

    // flush clears every entry including the branch itself
    assign flush_o = do_redirect;

    // strobes, high for one cycle after the retire edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
        end else begin
            commit_valid_o <= do_commit;
            redirect_o     <= do_redirect;
        end
    end

    // commit payload
    always_ff @(posedge clk) begin
        if (do_commit) begin
            commit_tag_o   <= head_ptr_i;
            commit_rd_o    <= head_rd_i;
            commit_value_o <= head_value_i;
        end
    end

    // redirect target
    always_ff @(posedge clk) begin
        if (do_redirect) begin
            redirect_pc_o <= head_target_i;
        end
    end

endmodule

// File: src/rob_top.sv
`timescale 1ns/1ns

module rob_top import rob_pkg::*; (
    input  logic                            clk,
    input  logic                            arst_n_i,

    // dispatch from decoder
    input  logic                            disp_valid_i,
    input  logic [CLASS_W-1:0]              disp_class_i,
    input  logic [4:0]                      disp_rd_i,
    output logic [TAG_W-1:0]                disp_tag_o,
    output logic                            full_o,
    output logic                            empty_o,

    // common data bus
    input  logic [NUM_CDB-1:0]              cdb_valid_i,
    input  logic [NUM_CDB-1:0][TAG_W-1:0]   cdb_tag_i,
    input  logic [NUM_CDB-1:0][XLEN-1:0]    cdb_value_i,
    input  logic [NUM_CDB-1:0][XLEN-1:0]    cdb_target_i,

    // load/store queue
    input  logic                            store_done_i,
    output logic                            head_is_store_o,
    output logic [TAG_W-1:0]                head_tag_o,

    // commit
    output logic                            commit_valid_o,
    output logic [TAG_W-1:0]                commit_tag_o,
    output logic [4:0]                      commit_rd_o,
    output logic [XLEN-1:0]                 commit_value_o,

    // fetch redirect
    output logic                            redirect_o,
    output logic [XLEN-1:0]                 redirect_pc_o
);

    // queue control to array
    logic [TAG_W-1:0]   head_ptr;
    logic [TAG_W-1:0]   tail_ptr;
    logic               disp_accept;

    // array to retire
    logic               head_busy;
    logic               head_done;
    logic [CLASS_W-1:0] head_class;
    logic [4:0]         head_rd;
    logic [XLEN-1:0]    head_value;
    logic [XLEN-1:0]    head_target;

    // retire back to the other two blocks
    logic               retire_head;
    logic               flush_req;

    // head entry tag for the lsq
    assign head_tag_o = head_ptr;

    rob_queue_ctrl queue_ctrl_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .disp_valid_i  (disp_valid_i),
        .retire_head_i (retire_head),
        .flush_i       (flush_req),
        .head_ptr_o    (head_ptr),
        .tail_ptr_o    (tail_ptr),
        .disp_accept_o (disp_accept),
        .full_o        (full_o),
        .empty_o       (empty_o),
        .disp_tag_o    (disp_tag_o)
    );

    // dispatch lands at the tail slot
    rob_entry_array entry_array_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .wr_en_i       (disp_accept),
        .wr_tag_i      (tail_ptr),
        .wr_class_i    (disp_class_i),
        .wr_rd_i       (disp_rd_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .cdb_value_i   (cdb_value_i),
        .cdb_target_i  (cdb_target_i),
        .head_ptr_i    (head_ptr),
        .retire_head_i (retire_head),
        .flush_i       (flush_req),
        .head_busy_o   (head_busy),
        .head_done_o   (head_done),
        .head_class_o  (head_class),
        .head_rd_o     (head_rd),
        .head_value_o  (head_value),
        .head_target_o (head_target)
    );

    rob_retire retire_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .head_ptr_i      (head_ptr),
        .head_busy_i     (head_busy),
        .head_done_i     (head_done),
        .head_class_i    (head_class),
        .head_rd_i       (head_rd),
        .head_value_i    (head_value),
        .head_target_i   (head_target),
        .store_done_i    (store_done_i),
        .retire_head_o   (retire_head),
        .flush_o         (flush_req),
        .head_is_store_o (head_is_store_o),
        .commit_valid_o  (commit_valid_o),
        .commit_tag_o    (commit_tag_o),
        .commit_rd_o     (commit_rd_o),
        .commit_value_o  (commit_value_o),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

endmodule

// File: verif/rob_assertions.sv
`timescale 1ns/1ns

module rob_assertions import rob_pkg::*; (
    input logic                          clk,
    input logic                          arst_n_i,
    input logic [CNT_W-1:0]              occ_cnt_i,
    input logic [ROB_ENTRIES-1:0]        busy_i,
    input logic                          disp_accept_i,
    input logic [TAG_W-1:0]              wr_tag_i,
    input logic                          empty_i,
    input logic                          commit_valid_i,
    input logic                          redirect_i,
    input logic [NUM_CDB-1:0]            cdb_valid_i,
    input logic [NUM_CDB-1:0][TAG_W-1:0] cdb_tag_i
);

    // count stays within the usable entries
    // and agrees with the busy flags in the array
    occ_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
        (occ_cnt_i <= CNT_W'(ROB_USABLE))
        && (occ_cnt_i == CNT_W'($countones(busy_i))))
        else $error("occupancy count %0d out of range or off the busy flags", occ_cnt_i);

    // one retire kind per cycle
    // queue already empty while the redirect is out
    commit_redirect_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i |-> (!commit_valid_i && empty_i))
        else $error("commit or live entries alongside a redirect");

    // two lanes never finish the same entry
    cdb_tag_unique: assert property (@(posedge clk) disable iff (!arst_n_i)
        (cdb_valid_i[0] && cdb_valid_i[1]) |-> (cdb_tag_i[0] != cdb_tag_i[1]))
        else $error("both cdb lanes carry tag %0d", cdb_tag_i[0]);

    // tail slot must be free when a dispatch lands
    no_write_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        disp_accept_i |-> !busy_i[wr_tag_i])
        else $error("dispatch overwrites busy entry %0d", wr_tag_i);

endmodule

bind rob_top rob_assertions rob_assertions_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .occ_cnt_i      (queue_ctrl_i.occ_cnt_q),
    .busy_i         (entry_array_i.busy_q),
    .disp_accept_i  (disp_accept),
    .wr_tag_i       (tail_ptr),
    .empty_i        (empty_o),
    .commit_valid_i (commit_valid_o),
    .redirect_i     (redirect_o),
    .cdb_valid_i    (cdb_valid_i),
    .cdb_tag_i      (cdb_tag_i)
);

// File: verif/rob_clock_gen.sv
`timescale 1ns/1ns

module rob_clock_gen (
    output logic clk,
    output logic arst_n_o
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset low across the first two rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n_o = 1'b1;
    end

endmodule

// File: verif/rob_tb.sv
`timescale 1ns/1ns

module rob_tb import rob_pkg::*; ();

    // tests finish in a few hundred cycles, generous margin
    localparam int MAX_CYCLES  = 2000;
    localparam int COMMIT_WAIT = 20;
    localparam logic [31:0] SEED = 32'ha10f4470;

    logic                          clk;
    logic                          arst_n_i;
    logic                          disp_valid_i;
    logic [CLASS_W-1:0]            disp_class_i;
    logic [4:0]                    disp_rd_i;
    logic [TAG_W-1:0]              disp_tag_o;
    logic                          full_o;
    logic                          empty_o;
    logic [NUM_CDB-1:0]            cdb_valid_i;
    logic [NUM_CDB-1:0][TAG_W-1:0] cdb_tag_i;
    logic [NUM_CDB-1:0][XLEN-1:0]  cdb_value_i;
    logic [NUM_CDB-1:0][XLEN-1:0]  cdb_target_i;
    logic                          store_done_i;
    logic                          head_is_store_o;
    logic [TAG_W-1:0]              head_tag_o;
    logic                          commit_valid_o;
    logic [TAG_W-1:0]              commit_tag_o;
    logic [4:0]                    commit_rd_o;
    logic [XLEN-1:0]               commit_value_o;
    logic                          redirect_o;
    logic [XLEN-1:0]               redirect_pc_o;

    // scoreboard: rd and broadcast value per tag, commit order queue
    logic [4:0]       sb_rd  [ROB_ENTRIES];
    logic [XLEN-1:0]  sb_val [ROB_ENTRIES];
    logic [TAG_W-1:0] exp_q  [$];
    logic [TAG_W-1:0] model_tail;
    int               commit_cnt = 0;
    int               redirect_cnt = 0;
    int               cycle_cnt = 0;

    rob_clock_gen clock_gen_i (.clk(clk), .arst_n_o(arst_n_i));

    rob_top rob_top_i (.*);

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] exp,
                             input logic [TAG_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected x%0d got x%0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch(input logic [CLASS_W-1:0] cls, output logic [TAG_W-1:0] tag);
        check_bit("full_o", 1'b0, full_o);
        check_tag("disp_tag_o", model_tail, disp_tag_o);
        tag = model_tail;
        sb_rd[tag] = 5'($urandom_range(31, 1));
        disp_valid_i = 1'b1;
        disp_class_i = cls;
        disp_rd_i = sb_rd[tag];
        step();
        disp_valid_i = 1'b0;
        if (cls == CLS_ALU || cls == CLS_LOAD) begin
            exp_q.push_back(tag);
        end
        // tail skips entry 0
        model_tail = (tag == TAG_W'(ROB_USABLE)) ? TAG_W'(1) : tag + 1'b1;
    endtask

    // one lane for one cycle, no scoreboard update
    task automatic send_cdb(input int lane, input logic [TAG_W-1:0] tag,
                            input logic [XLEN-1:0] value, input logic [XLEN-1:0] target);
        cdb_valid_i[lane] = 1'b1;
        cdb_tag_i[lane] = tag;
        cdb_value_i[lane] = value;
        cdb_target_i[lane] = target;
        step();
        cdb_valid_i = '0;
    endtask

    task automatic complete(input int lane, input logic [TAG_W-1:0] tag,
                            input logic [XLEN-1:0] value, input logic [XLEN-1:0] target);
        sb_val[tag] = value;
        send_cdb(lane, tag, value, target);
    endtask

    // both lanes in the same cycle
    task automatic complete_pair(input logic [TAG_W-1:0] tag0, input logic [XLEN-1:0] val0,
                                 input logic [TAG_W-1:0] tag1, input logic [XLEN-1:0] val1);
        sb_val[tag0] = val0;
        sb_val[tag1] = val1;
        cdb_valid_i = '1;
        cdb_tag_i = {tag1, tag0};
        cdb_value_i = {val1, val0};
        cdb_target_i = '0;
        step();
        cdb_valid_i = '0;
    endtask

    task automatic wait_commits(input int target);
        int idle;
        int last;
        idle = 0;
        last = commit_cnt;
        while (commit_cnt < target) begin
            step();
            idle = (commit_cnt != last) ? 0 : idle + 1;
            last = commit_cnt;
            if (idle > COMMIT_WAIT) begin
                $display("no commit within %0d cycles, %0d of %0d seen at %0t",
                         COMMIT_WAIT, commit_cnt, target, $time);
                abort_run();
            end
        end
    endtask

    task automatic hold_no_commit(input int cycles);
        int base;
        base = commit_cnt;
        repeat (cycles) step();
        if (commit_cnt != base) begin
            $display("commit seen while the head was still blocked at %0t", $time);
            abort_run();
        end
    endtask

    task automatic test_in_order();
        logic [TAG_W-1:0] tags [4];
        int base;
        base = commit_cnt;
        check_bit("empty_o", 1'b1, empty_o);
        check_bit("full_o", 1'b0, full_o);
        check_tag("disp_tag_o", TAG_W'(1), disp_tag_o);
        check_bit("redirect_o", 1'b0, redirect_o);
        check_bit("head_is_store_o", 1'b0, head_is_store_o);
        for (int i = 0; i < 4; i++) begin
            dispatch(CLS_ALU, tags[i]);
        end
        // youngest result first
        for (int i = 3; i >= 0; i--) begin
            complete(i % NUM_CDB, tags[i], $urandom(), '0);
        end
        wait_commits(base + 4);
        check_bit("empty_o", 1'b1, empty_o);
    endtask

    task automatic test_branches();
        logic [TAG_W-1:0] br;
        logic [TAG_W-1:0] alu_a;
        logic [TAG_W-1:0] alu_b;
        logic [XLEN-1:0]  tgt;
        int base;
        int redirects;
        base = commit_cnt;
        redirects = redirect_cnt;
        // not taken, leaves silently
        dispatch(CLS_BRANCH, br);
        dispatch(CLS_ALU, alu_a);
        complete(0, br, $urandom() & ~32'd1, $urandom());
        complete(1, alu_a, $urandom(), '0);
        wait_commits(base + 1);
        if (redirect_cnt != redirects) begin
            $display("not-taken branch raised a redirect at %0t", $time);
            abort_run();
        end
        // taken, younger finished ops get flushed
        dispatch(CLS_BRANCH, br);
        dispatch(CLS_ALU, alu_a);
        dispatch(CLS_ALU, alu_b);
        complete_pair(alu_a, $urandom(), alu_b, $urandom());
        tgt = $urandom();
        complete(0, br, $urandom() | 32'd1, tgt);
        step();
        check_bit("redirect_o", 1'b1, redirect_o);
        check_word("redirect_pc_o", tgt, redirect_pc_o);
        check_bit("empty_o", 1'b1, empty_o);
        check_tag("disp_tag_o", TAG_W'(1), disp_tag_o);
        exp_q.delete();
        model_tail = TAG_W'(1);
        step();
        check_bit("redirect_o", 1'b0, redirect_o);
        hold_no_commit(3);
    endtask

    task automatic test_full_wrap();
        logic [TAG_W-1:0] tags [ROB_USABLE];
        logic [TAG_W-1:0] extra;
        int base;
        base = commit_cnt;
        for (int i = 0; i < ROB_USABLE; i++) begin
            dispatch(CLS_ALU, tags[i]);
        end
        check_bit("full_o", 1'b1, full_o);
        // eighth dispatch bounces
        disp_valid_i = 1'b1;
        disp_rd_i = 5'd9;
        step();
        disp_valid_i = 1'b0;
        check_bit("full_o", 1'b1, full_o);
        check_tag("disp_tag_o", TAG_W'(1), disp_tag_o);
        complete(0, tags[0], $urandom(), '0);
        wait_commits(base + 1);
        check_bit("full_o", 1'b0, full_o);
        dispatch(CLS_ALU, extra);
        for (int i = 1; i < ROB_USABLE; i++) begin
            complete(i % NUM_CDB, tags[i], $urandom(), '0);
        end
        complete(1, extra, $urandom(), '0);
        wait_commits(base + ROB_USABLE + 1);
    endtask

    task automatic test_store_head();
        logic [TAG_W-1:0] st;
        logic [TAG_W-1:0] alu;
        int base;
        base = commit_cnt;
        dispatch(CLS_STORE, st);
        dispatch(CLS_ALU, alu);
        check_bit("head_is_store_o", 1'b1, head_is_store_o);
        check_tag("head_tag_o", st, head_tag_o);
        complete(0, alu, $urandom(), '0);
        hold_no_commit(5);
        // lsq reports the store performed
        store_done_i = 1'b1;
        step();
        store_done_i = 1'b0;
        wait_commits(base + 1);
        check_bit("head_is_store_o", 1'b0, head_is_store_o);
        check_bit("empty_o", 1'b1, empty_o);
    endtask

    task automatic test_dual_lane();
        logic [TAG_W-1:0] tags [3];
        int base;
        base = commit_cnt;
        for (int i = 0; i < 3; i++) begin
            dispatch(CLS_ALU, tags[i]);
        end
        complete_pair(tags[2], $urandom(), tags[1], $urandom());
        complete(1, tags[0], $urandom(), '0);
        wait_commits(base + 3);
    endtask

    task automatic test_stray_cdb();
        logic [TAG_W-1:0] t1;
        logic [TAG_W-1:0] t2;
        logic [TAG_W-1:0] t3;
        int base;
        base = commit_cnt;
        dispatch(CLS_ALU, t1);
        dispatch(CLS_ALU, t2);
        // free slot hit, then the slot gets dispatched
        send_cdb(1, model_tail, $urandom(), '0);
        dispatch(CLS_LOAD, t3);
        complete(0, t2, $urandom(), '0);
        // repeat on a done entry and on the null tag
        send_cdb(0, t2, $urandom(), '0);
        send_cdb(1, '0, $urandom(), '0);
        hold_no_commit(4);
        complete(1, t1, $urandom(), '0);
        wait_commits(base + 2);
        // load still waits for its own result
        hold_no_commit(4);
        complete(0, t3, $urandom(), '0);
        wait_commits(base + 3);
        check_bit("empty_o", 1'b1, empty_o);
    endtask

    // commit and redirect watcher, mid-cycle
    always @(negedge clk) begin : commit_monitor
        logic [TAG_W-1:0] tag;
        if (arst_n_i && redirect_o) begin
            redirect_cnt++;
        end
        if (arst_n_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("unexpected commit of tag %0d at %0t", commit_tag_o, $time);
                abort_run();
            end else begin
                tag = exp_q.pop_front();
                check_tag("commit_tag_o", tag, commit_tag_o);
                check_rd("commit_rd_o", sb_rd[tag], commit_rd_o);
                check_word("commit_value_o", sb_val[tag], commit_value_o);
                commit_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout after %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        disp_valid_i = 1'b0;
        disp_class_i = CLS_ALU;
        disp_rd_i = '0;
        cdb_valid_i = '0;
        cdb_tag_i = '0;
        cdb_value_i = '0;
        cdb_target_i = '0;
        store_done_i = 1'b0;
        model_tail = TAG_W'(1);
        @(posedge arst_n_i);
        step();
        test_in_order();
        test_branches();
        test_full_wrap();
        test_store_head();
        test_dual_lane();
        test_stray_cdb();
        if (exp_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_q.size());
            abort_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
